/* core_pkg.sv */
package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes handled by the pipeline
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct7 of OP, alt selects sub and sra
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_add    = 4'd0;
    localparam alu_op_t alu_sub    = 4'd1;
    localparam alu_op_t alu_sll    = 4'd2;
    localparam alu_op_t alu_slt    = 4'd3;
    localparam alu_op_t alu_sltu   = 4'd4;
    localparam alu_op_t alu_xor    = 4'd5;
    localparam alu_op_t alu_srl    = 4'd6;
    localparam alu_op_t alu_sra    = 4'd7;
    localparam alu_op_t alu_or     = 4'd8;
    localparam alu_op_t alu_and    = 4'd9;
    localparam alu_op_t alu_pass_b = 4'd10;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 is implied
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_word_t;

endpackage

/* fetch.sv */
`timescale 1ns/100ps

module fetch (
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     mem_wait,
    output logic                     inst_rden,
    output logic [core_pkg::xlen-1:0] inst_raddr
);
    import core_pkg::*;

    // address starts one word below 0 so the first request reads 0
    always_ff @(posedge CLK) begin
        if (RST) begin
            inst_rden  <= 1'b0;
            inst_raddr <= {{(xlen-2){1'b1}}, 2'b00};
        end else if (!mem_wait) begin
            inst_rden  <= 1'b1;
            inst_raddr <= inst_raddr + xlen'(4);
        end
    end

endmodule

/* decode_1.sv */
`timescale 1ns/100ps

module decode_1 (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            inst_valid,
    input  core_pkg::inst_word_t            inst_data,
    output logic                            decode1_valid,
    output logic [core_pkg::xlen-1:0]       decode1_pc,
    output logic [6:0]                      decode1_opcode,
    output logic [core_pkg::reg_addr_w-1:0] decode1_rd,
    output logic [core_pkg::reg_addr_w-1:0] decode1_rs1,
    output logic [core_pkg::reg_addr_w-1:0] decode1_rs2,
    output logic [2:0]                      decode1_funct3,
    output logic [6:0]                      decode1_funct7,
    output logic [core_pkg::xlen-1:0]       decode1_imm_i,
    output logic [core_pkg::xlen-1:0]       decode1_imm_s,
    output logic [core_pkg::xlen-1:0]       decode1_imm_b,
    output logic [core_pkg::xlen-1:0]       decode1_imm_u,
    output logic [core_pkg::xlen-1:0]       decode1_imm_j
);
    import core_pkg::*;

    // words received so far, pc is this count in words
    logic [xlen-3:0] word_cnt;

    always_ff @(posedge CLK) begin
        if (RST) begin
            decode1_valid <= 1'b0;
            word_cnt      <= '0;
        end else begin
            decode1_valid <= inst_valid;
            if (inst_valid) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (inst_valid) begin
            decode1_pc     <= {word_cnt, 2'b00};
            decode1_opcode <= inst_data.r.opcode;
            decode1_rd     <= inst_data.r.rd;
            decode1_rs1    <= inst_data.r.rs1;
            decode1_rs2    <= inst_data.r.rs2;
            decode1_funct3 <= inst_data.r.funct3;
            decode1_funct7 <= inst_data.r.funct7;
            // every immediate form, sign extended from its top bit
            decode1_imm_i  <= {{(xlen-12){inst_data.i.imm[11]}}, inst_data.i.imm};
            decode1_imm_s  <= {{(xlen-12){inst_data.s.imm_hi[6]}},
                               inst_data.s.imm_hi, inst_data.s.imm_lo};
            decode1_imm_b  <= {{(xlen-12){inst_data.b.imm_12}}, inst_data.b.imm_11,
                               inst_data.b.imm_10_5, inst_data.b.imm_4_1, 1'b0};
            decode1_imm_u  <= {inst_data.u.imm, 12'b0};
            decode1_imm_j  <= {{(xlen-20){inst_data.j.imm_20}}, inst_data.j.imm_19_12,
                               inst_data.j.imm_11, inst_data.j.imm_10_1, 1'b0};
        end
    end

endmodule

/* decode_2.sv */
`timescale 1ns/100ps

module decode_2 (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            decode1_valid,
    input  logic [core_pkg::xlen-1:0]       decode1_pc,
    input  logic [6:0]                      decode1_opcode,
    input  logic [core_pkg::reg_addr_w-1:0] decode1_rd,
    input  logic [core_pkg::reg_addr_w-1:0] decode1_rs1,
    input  logic [core_pkg::reg_addr_w-1:0] decode1_rs2,
    input  logic [2:0]                      decode1_funct3,
    input  logic [6:0]                      decode1_funct7,
    input  logic [core_pkg::xlen-1:0]       decode1_imm_i,
    input  logic [core_pkg::xlen-1:0]       decode1_imm_u,
    output logic                            decode2_valid,
    output logic [core_pkg::xlen-1:0]       decode2_pc,
    output logic [core_pkg::reg_addr_w-1:0] decode2_rd,
    output logic [core_pkg::reg_addr_w-1:0] decode2_rs1,
    output logic [core_pkg::reg_addr_w-1:0] decode2_rs2,
    output logic [core_pkg::xlen-1:0]       decode2_imm,
    output core_pkg::alu_op_t               decode2_alu_op,
    output logic                            decode2_use_imm,
    output logic                            decode2_use_pc,
    output logic                            decode2_writes
);
    import core_pkg::*;

    alu_op_t         arith_op;
    alu_op_t         alu_op;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            use_pc;
    logic            writes;

    // funct7 alt bit only counts for register sub, and for sra in both forms
    always_comb begin
        case (decode1_funct3)
            f3_add:  arith_op = (decode1_opcode == opc_op && decode1_funct7[5]) ?
                                alu_sub : alu_add;
            f3_sll:  arith_op = alu_sll;
            f3_slt:  arith_op = alu_slt;
            f3_sltu: arith_op = alu_sltu;
            f3_xor:  arith_op = alu_xor;
            f3_srl:  arith_op = decode1_funct7[5] ? alu_sra : alu_srl;
            f3_or:   arith_op = alu_or;
            f3_and:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    end

    always_comb begin
        alu_op  = arith_op;
        imm     = decode1_imm_i;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        writes  = 1'b0;
        case (decode1_opcode)
            opc_op: begin
                // other funct7 values belong to extensions, left as bubbles
                writes = decode1_funct7 == f7_base || decode1_funct7 == f7_alt;
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            opc_lui: begin
                alu_op  = alu_pass_b;
                imm     = decode1_imm_u;
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            opc_auipc: begin
                alu_op  = alu_add;
                imm     = decode1_imm_u;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                writes  = 1'b1;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    // register file read lands in the same cycle as these registers
    always_ff @(posedge CLK) begin
        if (RST) begin
            decode2_valid  <= 1'b0;
            decode2_writes <= 1'b0;
        end else begin
            decode2_valid  <= decode1_valid;
            decode2_writes <= decode1_valid && writes;
        end
        decode2_pc      <= decode1_pc;
        decode2_rd      <= decode1_rd;
        decode2_rs1     <= decode1_rs1;
        decode2_rs2     <= decode1_rs2;
        decode2_imm     <= imm;
        decode2_alu_op  <= alu_op;
        decode2_use_imm <= use_imm;
        decode2_use_pc  <= use_pc;
    end

    a_funct7_alt: assert property (@(posedge CLK) disable iff (RST)
        decode1_valid && decode1_opcode == opc_op && decode1_funct7[5]
        |-> decode1_funct3 == f3_add || decode1_funct3 == f3_srl)
        else $error("funct7 alt bit with funct3 %0d", decode1_funct3);

endmodule

/* register_file.sv */
`timescale 1ns/100ps

module register_file (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic [core_pkg::reg_addr_w-1:0] rd_addr_a,
    input  logic [core_pkg::reg_addr_w-1:0] rd_addr_b,
    output logic [core_pkg::xlen-1:0]       rd_data_a,
    output logic [core_pkg::xlen-1:0]       rd_data_b,
    input  logic                            wr_en,
    input  logic [core_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [core_pkg::xlen-1:0]       wr_data
);
    import core_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:(1 << reg_addr_w) - 1];

    // a write in the same cycle wins over the stored value
    function automatic logic [xlen-1:0] read_word(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge CLK) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
        rd_data_a <= read_word(rd_addr_a);
        rd_data_b <= read_word(rd_addr_b);
    end

    // exec drops rd 0 before it gets here
    a_no_x0_write: assert property (@(posedge CLK) disable iff (RST)
        wr_en |-> wr_addr != '0)
        else $error("register write to x0");

endmodule

/* exec.sv */
`timescale 1ns/100ps

module exec (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            decode2_valid,
    input  logic [core_pkg::xlen-1:0]       decode2_pc,
    input  logic [core_pkg::reg_addr_w-1:0] decode2_rd,
    input  logic [core_pkg::reg_addr_w-1:0] decode2_rs1,
    input  logic [core_pkg::reg_addr_w-1:0] decode2_rs2,
    input  logic [core_pkg::xlen-1:0]       decode2_imm,
    input  core_pkg::alu_op_t               decode2_alu_op,
    input  logic                            decode2_use_imm,
    input  logic                            decode2_use_pc,
    input  logic                            decode2_writes,
    input  logic [core_pkg::xlen-1:0]       rs1_data,
    input  logic [core_pkg::xlen-1:0]       rs2_data,
    output logic                            wb_valid,
    output logic [core_pkg::reg_addr_w-1:0] wb_rd,
    output logic [core_pkg::xlen-1:0]       wb_data
);
    import core_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;

    // previous instruction is still being written, the file read missed it
    // wb_valid is never set for rd 0, so x0 is never forwarded
    always_comb begin
        src_a = (wb_valid && wb_rd == decode2_rs1) ? wb_data : rs1_data;
        src_b = (wb_valid && wb_rd == decode2_rs2) ? wb_data : rs2_data;
        op_a  = decode2_use_pc ? decode2_pc : src_a;
        op_b  = decode2_use_imm ? decode2_imm : src_b;
    end

    always_comb begin
        case (decode2_alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << op_b[4:0];
            alu_slt:    result = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu:   result = xlen'(op_a < op_b);
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> op_b[4:0];
            alu_sra:    result = $signed(op_a) >>> op_b[4:0];
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= decode2_valid && decode2_writes && decode2_rd != '0;
        end
        wb_rd   <= decode2_rd;
        wb_data <= result;
    end

endmodule

/* core.sv */
`timescale 1ns/100ps

module core (
    input  logic                            CLK,
    input  logic                            RST,
    output logic                            inst_rden,
    output logic [core_pkg::xlen-1:0]       inst_raddr,
    input  logic                            inst_rvalid,
    input  logic [core_pkg::xlen-1:0]       inst_rdata,
    output logic                            data_rden,
    output logic [core_pkg::xlen-1:0]       data_raddr,
    input  logic                            data_rvalid,
    input  logic [core_pkg::xlen-1:0]       data_rdata,
    input  logic                            mem_wait,
    output logic                            wb_valid,
    output logic [core_pkg::reg_addr_w-1:0] wb_rd,
    output logic [core_pkg::xlen-1:0]       wb_data
);
    import core_pkg::*;

    // no loads yet
    assign data_rden  = 1'b0;
    assign data_raddr = '0;

    logic                  decode1_valid;
    logic [xlen-1:0]       decode1_pc;
    logic [6:0]            decode1_opcode;
    logic [reg_addr_w-1:0] decode1_rd;
    logic [reg_addr_w-1:0] decode1_rs1;
    logic [reg_addr_w-1:0] decode1_rs2;
    logic [2:0]            decode1_funct3;
    logic [6:0]            decode1_funct7;
    logic [xlen-1:0]       decode1_imm_i;
    logic [xlen-1:0]       decode1_imm_u;

    logic                  decode2_valid;
    logic [xlen-1:0]       decode2_pc;
    logic [reg_addr_w-1:0] decode2_rd;
    logic [reg_addr_w-1:0] decode2_rs1;
    logic [reg_addr_w-1:0] decode2_rs2;
    logic [xlen-1:0]       decode2_imm;
    alu_op_t               decode2_alu_op;
    logic                  decode2_use_imm;
    logic                  decode2_use_pc;
    logic                  decode2_writes;

    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    fetch fetch (
        .CLK        (CLK),
        .RST        (RST),
        .mem_wait   (mem_wait),
        .inst_rden  (inst_rden),
        .inst_raddr (inst_raddr)
    );

    // store, branch and jump immediates have no user yet
    decode_1 decode_1 (
        .CLK            (CLK),
        .RST            (RST),
        .inst_valid     (inst_rvalid),
        .inst_data      (inst_rdata),
        .decode1_valid  (decode1_valid),
        .decode1_pc     (decode1_pc),
        .decode1_opcode (decode1_opcode),
        .decode1_rd     (decode1_rd),
        .decode1_rs1    (decode1_rs1),
        .decode1_rs2    (decode1_rs2),
        .decode1_funct3 (decode1_funct3),
        .decode1_funct7 (decode1_funct7),
        .decode1_imm_i  (decode1_imm_i),
        .decode1_imm_s  (),
        .decode1_imm_b  (),
        .decode1_imm_u  (decode1_imm_u),
        .decode1_imm_j  ()
    );

    decode_2 decode_2 (
        .CLK             (CLK),
        .RST             (RST),
        .decode1_valid   (decode1_valid),
        .decode1_pc      (decode1_pc),
        .decode1_opcode  (decode1_opcode),
        .decode1_rd      (decode1_rd),
        .decode1_rs1     (decode1_rs1),
        .decode1_rs2     (decode1_rs2),
        .decode1_funct3  (decode1_funct3),
        .decode1_funct7  (decode1_funct7),
        .decode1_imm_i   (decode1_imm_i),
        .decode1_imm_u   (decode1_imm_u),
        .decode2_valid   (decode2_valid),
        .decode2_pc      (decode2_pc),
        .decode2_rd      (decode2_rd),
        .decode2_rs1     (decode2_rs1),
        .decode2_rs2     (decode2_rs2),
        .decode2_imm     (decode2_imm),
        .decode2_alu_op  (decode2_alu_op),
        .decode2_use_imm (decode2_use_imm),
        .decode2_use_pc  (decode2_use_pc),
        .decode2_writes  (decode2_writes)
    );

    // read addresses come straight from decode_1
    register_file register_file (
        .CLK       (CLK),
        .RST       (RST),
        .rd_addr_a (decode1_rs1),
        .rd_addr_b (decode1_rs2),
        .rd_data_a (rs1_data),
        .rd_data_b (rs2_data),
        .wr_en     (wb_valid),
        .wr_addr   (wb_rd),
        .wr_data   (wb_data)
    );

    exec exec (
        .CLK             (CLK),
        .RST             (RST),
        .decode2_valid   (decode2_valid),
        .decode2_pc      (decode2_pc),
        .decode2_rd      (decode2_rd),
        .decode2_rs1     (decode2_rs1),
        .decode2_rs2     (decode2_rs2),
        .decode2_imm     (decode2_imm),
        .decode2_alu_op  (decode2_alu_op),
        .decode2_use_imm (decode2_use_imm),
        .decode2_use_pc  (decode2_use_pc),
        .decode2_writes  (decode2_writes),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

endmodule

/* tb_core.sv */
`timescale 1ns/100ps

module tb_core;
    import core_pkg::*;

    localparam int prog_words = 64;
    localparam int init_words = 7;
    localparam int cycle_limit = 4 * prog_words + 50;

    logic                  CLK;
    logic                  RST;
    logic                  inst_rden;
    logic [xlen-1:0]       inst_raddr;
    logic                  inst_rvalid;
    logic [xlen-1:0]       inst_rdata;
    logic                  data_rden;
    logic [xlen-1:0]       data_raddr;
    logic                  data_rvalid;
    logic [xlen-1:0]       data_rdata;
    logic                  mem_wait;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;

    inst_word_t      prog [0:prog_words-1];
    logic [31:0]     lfsr;
    int              issued;
    int              received;
    int              cycles;
    int              burst_left;
    int              start_hold;
    logic            seen_go;
    logic [xlen-1:0] exp_addr;
    int              hits [1:6];
    int              fails [1:6];

    // expected write-back, delayed to line up with the pipeline
    logic            exp_chk [1:3];
    logic            exp_wr [1:3];
    logic [4:0]      exp_rd [1:3];
    logic [31:0]     exp_data [1:3];
    logic            exp_upper [1:3];
    logic            exp_dep [1:3];

    logic [31:0]     mregs [0:7];
    logic [4:0]      last_rd [0:2];

    core uut (
        .CLK         (CLK),
        .RST         (RST),
        .inst_rden   (inst_rden),
        .inst_raddr  (inst_raddr),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .data_rden   (data_rden),
        .data_raddr  (data_raddr),
        .data_rvalid (data_rvalid),
        .data_rdata  (data_rdata),
        .mem_wait    (mem_wait),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #10 CLK = ~CLK;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r[k] = lfsr[0];
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        inst_word_t  w;
        logic [3:0]  kind;
        logic        alt;
        for (int n = 0; n < prog_words; n++) begin
            w = '0;
            if (n < init_words) begin
                // give x1..x7 known values first
                w.i.opcode = opc_op_imm;
                w.i.rd     = 5'(n + 1);
                w.i.imm    = 12'(take_bits(12));
            end else begin
                kind = 4'(take_bits(4));
                alt  = take_bits(1) != 0;
                if (kind <= 4'd5 || kind >= 4'd14) begin
                    w.r.opcode = opc_op;
                    w.r.rd     = 5'(take_bits(3));
                    w.r.rs1    = 5'(take_bits(3));
                    w.r.rs2    = 5'(take_bits(3));
                    w.r.funct3 = 3'(take_bits(3));
                    if (alt && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5))
                        w.r.funct7 = 7'b0100000;
                end else if (kind <= 4'd10) begin
                    w.i.opcode = opc_op_imm;
                    w.i.rd     = 5'(take_bits(3));
                    w.i.rs1    = 5'(take_bits(3));
                    w.i.funct3 = 3'(take_bits(3));
                    w.i.imm    = 12'(take_bits(12));
                    // shifts carry a 5-bit amount and the sra flag
                    if (w.i.funct3 == 3'd1 || w.i.funct3 == 3'd5)
                        w.i.imm = {1'b0, alt && w.i.funct3 == 3'd5, 5'b0, w.i.imm[4:0]};
                end else if (kind <= 4'd12) begin
                    w.u.opcode = kind == 4'd11 ? opc_lui : opc_auipc;
                    w.u.rd     = 5'(take_bits(3));
                    w.u.imm    = 20'(take_bits(20));
                end else begin
                    // load opcode, outside scope
                    w = inst_word_t'(take_bits(32));
                    w.r.opcode = 7'b0000011;
                end
            end
            prog[n] = w;
        end
    endtask

    // memory model and mem_wait bursts
    always @(posedge CLK) begin : memory
        logic            req;
        logic            in_rst;
        logic [xlen-1:0] addr;
        req    = !RST && inst_rden && !mem_wait;
        in_rst = RST;
        addr   = inst_raddr;
        #1;
        inst_rvalid = 1'b0;
        if (req) begin
            inst_rvalid = 1'b1;
            inst_rdata  = prog[addr[7:2]];
            issued++;
        end
        if (in_rst || start_hold > 0 || issued >= prog_words) begin
            mem_wait = 1'b1;
            if (!in_rst && start_hold > 0)
                start_hold--;
        end else if (burst_left > 0) begin
            mem_wait = 1'b1;
            burst_left--;
        end else if (take_bits(3) == 0) begin
            mem_wait   = 1'b1;
            burst_left = int'(take_bits(2));
        end else begin
            mem_wait = 1'b0;
        end
    end

    // reference model, replays words in program order
    always @(posedge CLK) begin : model
        inst_word_t  w;
        logic        wr;
        logic        used1;
        logic        used2;
        logic [31:0] res;
        w     = inst_rdata;
        wr    = 1'b0;
        used1 = 1'b0;
        used2 = 1'b0;
        res   = '0;
        if (!RST && inst_rvalid) begin
            case (w.r.opcode)
                opc_op: begin
                    res   = ref_alu(w.r.funct3, w.r.funct7[5],
                                    mregs[w.r.rs1[2:0]], mregs[w.r.rs2[2:0]]);
                    wr    = 1'b1;
                    used1 = 1'b1;
                    used2 = 1'b1;
                end
                opc_op_imm: begin
                    res   = ref_alu(w.i.funct3, w.i.funct3 == 3'd5 && w.i.imm[10],
                                    mregs[w.i.rs1[2:0]], {{20{w.i.imm[11]}}, w.i.imm});
                    wr    = 1'b1;
                    used1 = 1'b1;
                end
                opc_lui: begin
                    res = {w.u.imm, 12'b0};
                    wr  = 1'b1;
                end
                opc_auipc: begin
                    res = 32'(received * 4) + {w.u.imm, 12'b0};
                    wr  = 1'b1;
                end
                default: wr = 1'b0;
            endcase
            wr = wr && w.r.rd != 5'd0;
            exp_dep[1] <= (used1 && w.r.rs1 != 0 && (w.r.rs1 == last_rd[0] ||
                           w.r.rs1 == last_rd[1] || w.r.rs1 == last_rd[2])) ||
                          (used2 && w.r.rs2 != 0 && (w.r.rs2 == last_rd[0] ||
                           w.r.rs2 == last_rd[1] || w.r.rs2 == last_rd[2]));
            last_rd[2] = last_rd[1];
            last_rd[1] = last_rd[0];
            last_rd[0] = wr ? w.r.rd : 5'd0;
            if (wr)
                mregs[w.r.rd[2:0]] = res;
            received++;
        end else begin
            exp_dep[1] <= 1'b0;
        end
        exp_chk[1]   <= !RST && inst_rvalid;
        exp_wr[1]    <= wr;
        exp_rd[1]    <= w.r.rd;
        exp_data[1]  <= res;
        exp_upper[1] <= w.r.opcode == opc_lui || w.r.opcode == opc_auipc;
        for (int s = 2; s <= 3; s++) begin
            exp_chk[s]   <= exp_chk[s-1];
            exp_wr[s]    <= exp_wr[s-1];
            exp_rd[s]    <= exp_rd[s-1];
            exp_data[s]  <= exp_data[s-1];
            exp_upper[s] <= exp_upper[s-1];
            exp_dep[s]   <= exp_dep[s-1];
        end
        if (!RST) begin
            if (!seen_go)
                hits[1]++;
            if (inst_rden && !mem_wait) begin
                hits[2]++;
                exp_addr <= exp_addr + 4;
            end
            if (!mem_wait)
                seen_go <= 1'b1;
            if (exp_chk[3])
                hits[3]++;
            if (exp_chk[3] && exp_wr[3] && !exp_upper[3])
                hits[4]++;
            if (exp_chk[3] && exp_wr[3] && exp_upper[3])
                hits[5]++;
            if (exp_chk[3] && exp_wr[3] && exp_dep[3])
                hits[6]++;
        end
    end

    a_idle_after_reset: assert property (@(posedge CLK) disable iff (RST)
        !seen_go |-> !inst_rden && !wb_valid)
        else begin
            $display("CHECK FAILED %0t: activity before first mem_wait low", $time);
            fails[1]++;
        end

    // data read port stays tied off for the whole run
    a_data_idle: assert property (@(posedge CLK) disable iff (RST)
        !data_rden && data_raddr == '0)
        else begin
            $display("CHECK FAILED %0t: data read rden %b addr %h, expected 0",
                     $time, data_rden, data_raddr);
            fails[1]++;
        end

    a_req_addr: assert property (@(posedge CLK) disable iff (RST)
        inst_rden && !mem_wait |-> inst_raddr == exp_addr)
        else begin
            $display("CHECK FAILED %0t: request address %h, expected %h",
                     $time, inst_raddr, exp_addr);
            fails[2]++;
        end

    a_hold_wait: assert property (@(posedge CLK) disable iff (RST)
        mem_wait |=> $stable(inst_raddr) && $stable(inst_rden))
        else begin
            $display("CHECK FAILED %0t: request changed under mem_wait", $time);
            fails[2]++;
        end

    a_wb_timing: assert property (@(posedge CLK) disable iff (RST)
        exp_chk[3] |-> wb_valid == exp_wr[3] && (!exp_wr[3] || wb_rd == exp_rd[3]))
        else begin
            $display("CHECK FAILED %0t: wb_valid %b rd %0d, expected %b rd %0d",
                     $time, wb_valid, wb_rd, exp_wr[3], exp_rd[3]);
            fails[3]++;
        end

    a_no_stray_wb: assert property (@(posedge CLK) disable iff (RST)
        !exp_chk[3] |-> !wb_valid)
        else begin
            $display("CHECK FAILED %0t: write-back without an instruction", $time);
            fails[3]++;
        end

    a_alu_data: assert property (@(posedge CLK) disable iff (RST)
        exp_chk[3] && exp_wr[3] && !exp_upper[3] |-> wb_data == exp_data[3])
        else begin
            $display("CHECK FAILED %0t: ALU result %h, expected %h",
                     $time, wb_data, exp_data[3]);
            fails[4]++;
        end

    a_upper_data: assert property (@(posedge CLK) disable iff (RST)
        exp_chk[3] && exp_wr[3] && exp_upper[3] |-> wb_data == exp_data[3])
        else begin
            $display("CHECK FAILED %0t: LUI/AUIPC result %h, expected %h",
                     $time, wb_data, exp_data[3]);
            fails[5]++;
        end

    a_dep_data: assert property (@(posedge CLK) disable iff (RST)
        exp_chk[3] && exp_wr[3] && exp_dep[3] |-> wb_data == exp_data[3])
        else begin
            $display("CHECK FAILED %0t: dependent result %h, expected %h",
                     $time, wb_data, exp_data[3]);
            fails[6]++;
        end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: pipeline did not finish the program in %0d cycles",
                     cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : main
        string names [1:6];
        int    total_fail;
        int    total_hits;
        names = '{"idle after reset", "fetch addresses", "write-back timing",
                  "ALU results", "LUI and AUIPC", "dependent instructions"};
        CLK = 1'b0;
        RST = 1'b1;
        inst_rvalid = 1'b0;
        inst_rdata  = '0;
        data_rvalid = 1'b0;
        data_rdata  = '0;
        mem_wait    = 1'b1;
        lfsr        = 32'd90862;
        issued      = 0;
        received    = 0;
        cycles      = 0;
        burst_left  = 0;
        start_hold  = 3;
        seen_go     = 1'b0;
        exp_addr    = '0;
        total_fail  = 0;
        total_hits  = 0;
        for (int k = 1; k <= 6; k++) begin
            hits[k]  = 0;
            fails[k] = 0;
        end
        for (int k = 0; k < 8; k++)
            mregs[k] = '0;
        for (int k = 0; k < 3; k++)
            last_rd[k] = '0;
        build_program();
        repeat (4) @(posedge CLK);
        #1 RST = 1'b0;
        while (received < prog_words)
            @(posedge CLK);
        repeat (5) @(posedge CLK);
        for (int k = 1; k <= 6; k++) begin
            $display("test %0d %s: %0d checks, %0d failures", k, names[k], hits[k], fails[k]);
            total_fail += fails[k];
            total_hits += hits[k];
        end
        $display("checks %0d, failures %0d", total_hits, total_fail);
        if (total_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* core.f */
core_pkg.sv
fetch.sv
decode_1.sv
decode_2.sv
register_file.sv
exec.sv
core.sv
tb_core.sv

/* run_sim.sh */
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_core -f core.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
